// File: wb_pkg.sv
`default_nettype none

package wb_pkg;

    // Word address width of the shared bus.
    localparam int addr_width_default = 8;

    // Data width of every port and of the RAM.
    localparam int data_width_default = 32;

    // One byte select per data byte.
    localparam int strobe_width_default = data_width_default / 8;

    // Write response code returned on the response channel.
    localparam int resp_width = 1;
    localparam logic [resp_width-1:0] resp_done = 1'b1;

    // Number of Wishbone masters sharing the slave bus.
    localparam int arbiter_ports = 2;

endpackage

`default_nettype wire

// File: wb_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_adapter #(
    parameter int addr_width = wb_pkg::addr_width_default,
    parameter int data_width = wb_pkg::data_width_default,
    parameter int strobe_width = data_width / 8
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          r_addr_valid,
    output logic                          r_addr_ready,
    input  logic [addr_width-1:0]         r_addr,
    output logic                          r_data_valid,
    input  logic                          r_data_ready,
    output logic [data_width-1:0]         r_data,
    input  logic                          w_valid,
    output logic                          w_ready,
    input  logic [addr_width-1:0]         w_addr,
    input  logic [data_width-1:0]         w_data,
    input  logic [strobe_width-1:0]       w_strobe,
    output logic                          w_resp_valid,
    input  logic                          w_resp_ready,
    output logic [wb_pkg::resp_width-1:0] w_resp,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic                          wb_we,
    output logic [addr_width-1:0]         wb_adr,
    output logic [data_width-1:0]         wb_dat_w,
    output logic [strobe_width-1:0]       wb_sel,
    input  logic [data_width-1:0]         wb_dat_r,
    input  logic                          wb_ack
);

    // A request sits in the master registers for one cycle before the cycle opens.
    logic pending;
    logic idle;
    logic take_read;
    logic take_write;

    assign idle = !pending && !wb_cyc && !r_data_valid && !w_resp_valid;

    // A read wins over a write offered in the same cycle.
    assign r_addr_ready = idle;
    assign w_ready = idle && !r_addr_valid;

    assign take_read = r_addr_valid && r_addr_ready;
    assign take_write = w_valid && w_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= 1'b0;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end else if (take_read || take_write) begin
            pending <= 1'b1;
        end else if (pending) begin
            pending <= 1'b0;
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
        end else if (wb_cyc && wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take_read) begin
            wb_we <= 1'b0;
            wb_adr <= r_addr;
            wb_sel <= '1;
        end else if (take_write) begin
            wb_we <= 1'b1;
            wb_adr <= w_addr;
            wb_dat_w <= w_data;
            wb_sel <= w_strobe;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            r_data_valid <= 1'b0;
        end else if (wb_cyc && wb_ack && !wb_we) begin
            r_data_valid <= 1'b1;
        end else if (r_data_ready) begin
            r_data_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            w_resp_valid <= 1'b0;
        end else if (wb_cyc && wb_ack && wb_we) begin
            w_resp_valid <= 1'b1;
        end else if (w_resp_ready) begin
            w_resp_valid <= 1'b0;
        end
    end

    // The payloads only load on ack, so they hold while the response waits.
    always_ff @(posedge clock) begin
        if (wb_cyc && wb_ack) begin
            if (wb_we) begin
                w_resp <= wb_pkg::resp_done;
            end else begin
                r_data <= wb_dat_r;
            end
        end
    end

    stb_within_cyc: assert property (@(posedge clock) disable iff (reset)
        wb_stb |-> wb_cyc);

    // The arbiter must never route the slave's ack to a master that is not in a cycle.
    ack_within_cyc: assert property (@(posedge clock) disable iff (reset)
        wb_ack |-> wb_cyc);

endmodule

`default_nettype wire

// File: wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter #(
    parameter int addr_width = wb_pkg::addr_width_default,
    parameter int data_width = wb_pkg::data_width_default,
    parameter int strobe_width = data_width / 8
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    m0_cyc,
    input  logic                    m0_stb,
    input  logic                    m0_we,
    input  logic [addr_width-1:0]   m0_adr,
    input  logic [data_width-1:0]   m0_dat_w,
    input  logic [strobe_width-1:0] m0_sel,
    output logic [data_width-1:0]   m0_dat_r,
    output logic                    m0_ack,
    input  logic                    m1_cyc,
    input  logic                    m1_stb,
    input  logic                    m1_we,
    input  logic [addr_width-1:0]   m1_adr,
    input  logic [data_width-1:0]   m1_dat_w,
    input  logic [strobe_width-1:0] m1_sel,
    output logic [data_width-1:0]   m1_dat_r,
    output logic                    m1_ack,
    output logic                    s_cyc,
    output logic                    s_stb,
    output logic                    s_we,
    output logic [addr_width-1:0]   s_adr,
    output logic [data_width-1:0]   s_dat_w,
    output logic [strobe_width-1:0] s_sel,
    input  logic [data_width-1:0]   s_dat_r,
    input  logic                    s_ack
);

    // The owner is one-hot and reads all zero while the bus is free.
    logic [wb_pkg::arbiter_ports-1:0] owner;
    logic last;
    logic held;
    logic grant;

    assign held = (owner[0] && m0_cyc) || (owner[1] && m1_cyc);

    always_comb begin
        if (held) begin
            grant = owner[1];
        end else if (m0_cyc && m1_cyc) begin
            grant = !last;
        end else begin
            grant = m1_cyc;
        end
    end

    // Port 0 goes first after reset.
    always_ff @(posedge clock) begin
        if (reset) begin
            owner <= '0;
            last <= 1'b1;
        end else begin
            owner <= '0;
            if (s_cyc) begin
                owner[grant] <= 1'b1;
            end
            if (s_cyc && !held) begin
                last <= grant;
            end
        end
    end

    assign s_cyc = grant ? m1_cyc : m0_cyc;
    assign s_stb = grant ? m1_stb : m0_stb;
    assign s_we = grant ? m1_we : m0_we;
    assign s_adr = grant ? m1_adr : m0_adr;
    assign s_dat_w = grant ? m1_dat_w : m0_dat_w;
    assign s_sel = grant ? m1_sel : m0_sel;

    // Read data goes to both masters; only the owner sees ack.
    assign m0_dat_r = s_dat_r;
    assign m1_dat_r = s_dat_r;
    assign m0_ack = s_ack && !grant;
    assign m1_ack = s_ack && grant;

    one_ack: assert property (@(posedge clock) disable iff (reset)
        !(m0_ack && m1_ack));

    owner_0_locked: assert property (@(posedge clock) disable iff (reset)
        (owner[0] && m0_cyc) |=> owner[0]);

    owner_1_locked: assert property (@(posedge clock) disable iff (reset)
        (owner[1] && m1_cyc) |=> owner[1]);

endmodule

`default_nettype wire

// File: wb_ram.sv
`timescale 1ns/1ps
`default_nettype none

module wb_ram #(
    parameter int addr_width = wb_pkg::addr_width_default,
    parameter int data_width = wb_pkg::data_width_default,
    parameter int strobe_width = data_width / 8
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [addr_width-1:0]   adr,
    input  logic [data_width-1:0]   dat_w,
    input  logic [strobe_width-1:0] sel,
    output logic [data_width-1:0]   dat_r,
    output logic                    ack
);

    localparam int depth = 2 ** addr_width;

    logic [data_width-1:0] mem [depth];
    logic access;

    // The cycle after ack is never a new access, so a held strobe is served once.
    assign access = cyc && stb && !ack;

    always_ff @(posedge clock) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    always_ff @(posedge clock) begin
        if (access) begin
            if (we) begin
                for (int i = 0; i < strobe_width; i++) begin
                    if (sel[i]) begin
                        mem[adr][i*8 +: 8] <= dat_w[i*8 +: 8];
                    end
                end
            end else begin
                dat_r <= mem[adr];
            end
        end
    end

    single_cycle_ack: assert property (@(posedge clock) disable iff (reset)
        ack |=> !ack);

endmodule

`default_nettype wire

// File: wb_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module wb_subsystem #(
    parameter int addr_width = wb_pkg::addr_width_default,
    parameter int data_width = wb_pkg::data_width_default,
    parameter int strobe_width = wb_pkg::strobe_width_default
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          p0_r_addr_valid,
    output logic                          p0_r_addr_ready,
    input  logic [addr_width-1:0]         p0_r_addr,
    output logic                          p0_r_data_valid,
    input  logic                          p0_r_data_ready,
    output logic [data_width-1:0]         p0_r_data,
    input  logic                          p0_w_valid,
    output logic                          p0_w_ready,
    input  logic [addr_width-1:0]         p0_w_addr,
    input  logic [data_width-1:0]         p0_w_data,
    input  logic [strobe_width-1:0]       p0_w_strobe,
    output logic                          p0_w_resp_valid,
    input  logic                          p0_w_resp_ready,
    output logic [wb_pkg::resp_width-1:0] p0_w_resp,
    input  logic                          p1_r_addr_valid,
    output logic                          p1_r_addr_ready,
    input  logic [addr_width-1:0]         p1_r_addr,
    output logic                          p1_r_data_valid,
    input  logic                          p1_r_data_ready,
    output logic [data_width-1:0]         p1_r_data,
    input  logic                          p1_w_valid,
    output logic                          p1_w_ready,
    input  logic [addr_width-1:0]         p1_w_addr,
    input  logic [data_width-1:0]         p1_w_data,
    input  logic [strobe_width-1:0]       p1_w_strobe,
    output logic                          p1_w_resp_valid,
    input  logic                          p1_w_resp_ready,
    output logic [wb_pkg::resp_width-1:0] p1_w_resp
);

    // Master side of each adapter.
    logic                    m0_cyc, m0_stb, m0_we, m0_ack;
    logic [addr_width-1:0]   m0_adr;
    logic [data_width-1:0]   m0_dat_w, m0_dat_r;
    logic [strobe_width-1:0] m0_sel;
    logic                    m1_cyc, m1_stb, m1_we, m1_ack;
    logic [addr_width-1:0]   m1_adr;
    logic [data_width-1:0]   m1_dat_w, m1_dat_r;
    logic [strobe_width-1:0] m1_sel;

    // Shared bus between the arbiter and the RAM.
    logic                    s_cyc, s_stb, s_we, s_ack;
    logic [addr_width-1:0]   s_adr;
    logic [data_width-1:0]   s_dat_w, s_dat_r;
    logic [strobe_width-1:0] s_sel;

    wb_adapter #(
        .addr_width(addr_width), .data_width(data_width), .strobe_width(strobe_width)
    ) adapter_0 (
        .clock(clock), .reset(reset),
        .r_addr_valid(p0_r_addr_valid), .r_addr_ready(p0_r_addr_ready), .r_addr(p0_r_addr),
        .r_data_valid(p0_r_data_valid), .r_data_ready(p0_r_data_ready), .r_data(p0_r_data),
        .w_valid(p0_w_valid), .w_ready(p0_w_ready), .w_addr(p0_w_addr),
        .w_data(p0_w_data), .w_strobe(p0_w_strobe),
        .w_resp_valid(p0_w_resp_valid), .w_resp_ready(p0_w_resp_ready), .w_resp(p0_w_resp),
        .wb_cyc(m0_cyc), .wb_stb(m0_stb), .wb_we(m0_we), .wb_adr(m0_adr),
        .wb_dat_w(m0_dat_w), .wb_sel(m0_sel), .wb_dat_r(m0_dat_r), .wb_ack(m0_ack)
    );

    wb_adapter #(
        .addr_width(addr_width), .data_width(data_width), .strobe_width(strobe_width)
    ) adapter_1 (
        .clock(clock), .reset(reset),
        .r_addr_valid(p1_r_addr_valid), .r_addr_ready(p1_r_addr_ready), .r_addr(p1_r_addr),
        .r_data_valid(p1_r_data_valid), .r_data_ready(p1_r_data_ready), .r_data(p1_r_data),
        .w_valid(p1_w_valid), .w_ready(p1_w_ready), .w_addr(p1_w_addr),
        .w_data(p1_w_data), .w_strobe(p1_w_strobe),
        .w_resp_valid(p1_w_resp_valid), .w_resp_ready(p1_w_resp_ready), .w_resp(p1_w_resp),
        .wb_cyc(m1_cyc), .wb_stb(m1_stb), .wb_we(m1_we), .wb_adr(m1_adr),
        .wb_dat_w(m1_dat_w), .wb_sel(m1_sel), .wb_dat_r(m1_dat_r), .wb_ack(m1_ack)
    );

    wb_arbiter #(
        .addr_width(addr_width), .data_width(data_width), .strobe_width(strobe_width)
    ) arbiter (
        .clock(clock), .reset(reset),
        .m0_cyc(m0_cyc), .m0_stb(m0_stb), .m0_we(m0_we), .m0_adr(m0_adr),
        .m0_dat_w(m0_dat_w), .m0_sel(m0_sel), .m0_dat_r(m0_dat_r), .m0_ack(m0_ack),
        .m1_cyc(m1_cyc), .m1_stb(m1_stb), .m1_we(m1_we), .m1_adr(m1_adr),
        .m1_dat_w(m1_dat_w), .m1_sel(m1_sel), .m1_dat_r(m1_dat_r), .m1_ack(m1_ack),
        .s_cyc(s_cyc), .s_stb(s_stb), .s_we(s_we), .s_adr(s_adr),
        .s_dat_w(s_dat_w), .s_sel(s_sel), .s_dat_r(s_dat_r), .s_ack(s_ack)
    );

    wb_ram #(
        .addr_width(addr_width), .data_width(data_width), .strobe_width(strobe_width)
    ) ram (
        .clock(clock), .reset(reset),
        .cyc(s_cyc), .stb(s_stb), .we(s_we), .adr(s_adr),
        .dat_w(s_dat_w), .sel(s_sel), .dat_r(s_dat_r), .ack(s_ack)
    );

endmodule

`default_nettype wire

// File: tb_wb_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_subsystem;

    localparam int addr_width = wb_pkg::addr_width_default;
    localparam int data_width = wb_pkg::data_width_default;
    localparam int strobe_width = data_width / 8;
    localparam int clock_period = 8;
    localparam int fields = 11;
    localparam int max_records = 64;
    localparam logic [31:0] end_mark = 32'hff;

    logic clock = 1'b0;
    logic reset;
    logic [1:0] r_addr_valid, r_addr_ready, r_data_valid, r_data_ready;
    logic [1:0] w_valid, w_ready, w_resp_valid, w_resp_ready;
    logic [addr_width-1:0] r_addr [2];
    logic [data_width-1:0] r_data [2];
    logic [addr_width-1:0] w_addr [2];
    logic [data_width-1:0] w_data [2];
    logic [strobe_width-1:0] w_strobe [2];
    logic [wb_pkg::resp_width-1:0] w_resp [2];

    logic [31:0] testdata [max_records * fields];
    logic [31:0] rng_state = 32'hb3d5b2fc;
    int record_count = 0;
    int errors = 0;
    int cycle = 0;
    int rise [2];
    int accept [2];
    logic [1:0] prev_valid = 2'b00;
    // Port 0 has priority after reset, as if port 1 had been granted last.
    logic last_grant = 1'b1;

    always #(clock_period / 2) clock = ~clock;

    wb_subsystem #(
        .addr_width(addr_width), .data_width(data_width), .strobe_width(strobe_width)
    ) DUT (
        .clock(clock), .reset(reset),
        .p0_r_addr_valid(r_addr_valid[0]), .p0_r_addr_ready(r_addr_ready[0]),
        .p0_r_addr(r_addr[0]), .p0_r_data_valid(r_data_valid[0]),
        .p0_r_data_ready(r_data_ready[0]), .p0_r_data(r_data[0]),
        .p0_w_valid(w_valid[0]), .p0_w_ready(w_ready[0]), .p0_w_addr(w_addr[0]),
        .p0_w_data(w_data[0]), .p0_w_strobe(w_strobe[0]),
        .p0_w_resp_valid(w_resp_valid[0]), .p0_w_resp_ready(w_resp_ready[0]),
        .p0_w_resp(w_resp[0]),
        .p1_r_addr_valid(r_addr_valid[1]), .p1_r_addr_ready(r_addr_ready[1]),
        .p1_r_addr(r_addr[1]), .p1_r_data_valid(r_data_valid[1]),
        .p1_r_data_ready(r_data_ready[1]), .p1_r_data(r_data[1]),
        .p1_w_valid(w_valid[1]), .p1_w_ready(w_ready[1]), .p1_w_addr(w_addr[1]),
        .p1_w_data(w_data[1]), .p1_w_strobe(w_strobe[1]),
        .p1_w_resp_valid(w_resp_valid[1]), .p1_w_resp_ready(w_resp_ready[1]),
        .p1_w_resp(w_resp[1])
    );

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // Records the cycle on which each port's response valid rises.
    always @(negedge clock) begin
        for (int p = 0; p < 2; p++) begin
            if ((r_data_valid[p] || w_resp_valid[p]) && !prev_valid[p]) begin
                rise[p] = cycle;
            end
            prev_valid[p] = r_data_valid[p] || w_resp_valid[p];
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic response_valid(input int p, input logic read);
        return read ? r_data_valid[p] : w_resp_valid[p];
    endfunction

    function automatic logic [31:0] response_payload(input int p, input logic read);
        return read ? r_data[p] : 32'(w_resp[p]);
    endfunction

    task automatic report_value(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        errors++;
        $display("FAILED %s expected %h actual %h", name, expected, actual);
    endtask

    task automatic report_text(input string text);
        errors++;
        $display("Error: %s", text);
    endtask

    // Issues one request on port p from the record fields at offset at, checks the
    // response and holds its ready low for hold extra cycles.
    task automatic run_op(input int p, input int at, input int hold);
        logic read;
        logic [31:0] expected;
        logic [31:0] payload;
        string name;

        read = testdata[at] == 32'd1;
        expected = read ? testdata[at + 4] : 32'(wb_pkg::resp_done);
        name = $sformatf("p%0d_%s", p, read ? "r_data" : "w_resp");
        @(posedge clock);
        if (read) begin
            r_addr_valid[p] <= 1'b1;
            r_addr[p] <= testdata[at + 1][addr_width-1:0];
        end else begin
            w_valid[p] <= 1'b1;
            w_addr[p] <= testdata[at + 1][addr_width-1:0];
            w_data[p] <= testdata[at + 2];
            w_strobe[p] <= testdata[at + 3][strobe_width-1:0];
        end
        @(negedge clock);
        while (!(read ? r_addr_ready[p] : w_ready[p])) begin
            @(negedge clock);
        end
        accept[p] = cycle + 1;
        @(posedge clock);
        r_addr_valid[p] <= 1'b0;
        w_valid[p] <= 1'b0;
        @(negedge clock);
        while (!response_valid(p, read)) begin
            @(negedge clock);
        end
        payload = response_payload(p, read);
        if (payload !== expected) begin
            report_value(name, expected, payload);
        end
        for (int n = 0; n <= hold; n++) begin
            if (n > 0) begin
                @(negedge clock);
                if (!response_valid(p, read)) begin
                    report_value({name, "_valid"}, 32'd1, 32'd0);
                end
                if (response_payload(p, read) !== payload) begin
                    report_value(name, payload, response_payload(p, read));
                end
            end
            if (r_addr_ready[p] || w_ready[p]) begin
                report_value($sformatf("p%0d request ready", p), 32'd0,
                    32'({r_addr_ready[p], w_ready[p]}));
            end
        end
        @(posedge clock);
        if (read) begin
            r_data_ready[p] <= 1'b1;
        end else begin
            w_resp_ready[p] <= 1'b1;
        end
        @(posedge clock);
        r_data_ready[p] <= 1'b0;
        w_resp_ready[p] <= 1'b0;
    endtask

    initial begin
        int count;
        int base;
        int mode;
        int hold [2];
        logic winner;

        reset <= 1'b1;
        r_addr_valid <= '0;
        r_data_ready <= '0;
        w_valid <= '0;
        w_resp_ready <= '0;
        for (int p = 0; p < 2; p++) begin
            r_addr[p] <= '0;
            w_addr[p] <= '0;
            w_data[p] <= '0;
            w_strobe[p] <= '0;
        end
        $readmemh("wb_testdata.mem", testdata);
        count = 0;
        while (count < max_records && testdata[count * fields] != end_mark) begin
            count++;
        end
        if (count == 0 || count == max_records) begin
            report_text("the test data file holds no records or lacks its end marker");
            count = 0;
        end
        record_count = count;

        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (r_addr_ready !== 2'b11) begin
            report_value("r_addr_ready", 32'h3, 32'(r_addr_ready));
        end
        if (w_ready !== 2'b11) begin
            report_value("w_ready", 32'h3, 32'(w_ready));
        end
        if (r_data_valid !== 2'b00) begin
            report_value("r_data_valid", 32'h0, 32'(r_data_valid));
        end
        if (w_resp_valid !== 2'b00) begin
            report_value("w_resp_valid", 32'h0, 32'(w_resp_valid));
        end

        for (int i = 0; i < record_count; i++) begin
            base = i * fields;
            mode = testdata[base];
            for (int p = 0; p < 2; p++) begin
                rng_state = xorshift32(rng_state);
                hold[p] = rng_state % 4;
            end
            if (mode == 2) begin
                fork
                    run_op(0, base + 1, hold[0]);
                    run_op(1, base + 6, hold[1]);
                join
                if (rise[0] == rise[1]) begin
                    report_text("both ports raised their responses in the same cycle");
                end
                // The port not granted last goes first. The other port then
                // takes the bus, so the last grant ends up where it was.
                winner = rise[1] < rise[0];
                if (winner != !last_grant) begin
                    report_value("first response port", 32'(!last_grant), 32'(winner));
                end
            end else if (mode == 0 || mode == 1) begin
                run_op(mode, base + 1 + 5 * mode, hold[mode]);
                if (rise[mode] - accept[mode] != 3) begin
                    report_value($sformatf("p%0d response latency", mode), 32'd3,
                        rise[mode] - accept[mode]);
                end
                last_grant = mode[0];
            end else begin
                report_text($sformatf("record %0d has an unknown issue mode", i));
            end
        end

        $display("%0d records run, %0d errors", record_count, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        wait (record_count > 0);
        #(record_count * 40 * clock_period);
        $display("Timeout: the run did not finish in the time allowed for %0d records",
            record_count);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: wb_testdata.mem
// Columns: mode, then op addr data strobe expected for port 0, then the same for port 1.
// Mode 0 port 0 alone, 1 port 1 alone, 2 both together, ff ends. Op 0 write, 1 read.
2 0 10 11223344 f 0 0 11 55667788 f 0
0 1 10 0 0 11223344 0 0 0 0 0
1 0 0 0 0 0 1 10 0 0 11223344
0 1 11 0 0 55667788 0 0 0 0 0
2 1 11 0 0 55667788 1 10 0 0 11223344
1 0 0 0 0 0 0 20 a5a5a5a5 f 0
1 0 0 0 0 0 1 20 0 0 a5a5a5a5
0 1 20 0 0 a5a5a5a5 0 0 0 0 0
0 0 20 000000ff 1 0 0 0 0 0 0
1 0 0 0 0 0 1 20 0 0 a5a5a5ff
1 0 0 0 0 0 0 20 12340000 c 0
0 1 20 0 0 1234a5ff 0 0 0 0 0
2 0 30 deadbeef f 0 0 31 cafef00d f 0
0 0 30 0000ca00 2 0 0 0 0 0 0
1 0 0 0 0 0 1 30 0 0 deadcaef
2 1 31 0 0 cafef00d 1 30 0 0 deadcaef
1 0 0 0 0 0 0 30 00770000 4 0
0 1 30 0 0 de77caef 0 0 0 0 0
1 0 0 0 0 0 0 31 00000011 1 0
2 0 40 0f0f0f0f f 0 1 31 0 0 cafef011
0 1 40 0 0 0f0f0f0f 0 0 0 0 0
0 0 40 f0000000 8 0 0 0 0 0 0
2 1 40 0 0 f00f0f0f 0 41 00ab00cd f 0
1 0 0 0 0 0 1 41 0 0 00ab00cd
0 0 41 11000022 9 0 0 0 0 0 0
1 0 0 0 0 0 1 41 0 0 11ab0022
2 1 41 0 0 11ab0022 1 40 0 0 f00f0f0f
1 0 0 0 0 0 0 ff 89abcdef f 0
0 1 ff 0 0 89abcdef 0 0 0 0 0
0 0 00 76543210 f 0 0 0 0 0 0
2 1 00 0 0 76543210 1 ff 0 0 89abcdef
1 0 0 0 0 0 0 00 0000aa00 2 0
2 1 00 0 0 7654aa10 0 10 ffffffff 0 0
0 1 10 0 0 11223344 0 0 0 0 0
ff

// File: tb.f
wb_pkg.sv
wb_adapter.sv
wb_arbiter.sv
wb_ram.sv
wb_subsystem.sv
tb_wb_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_wb_subsystem \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
